// ==== Bender.yml ====
package:
  name: dga_decode

sources:
  - include_dirs:
      - .
    files:
      - dga_pkg.sv
      - dga_tick_if.sv
      - panel_timebase.sv
      - power_monitor.sv
      - panel_control.sv
      - refresh_requester.sv
      - dga_decode_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dga_tb.sv

// ==== all.f ====
+incdir+.
dga_pkg.sv
dga_tick_if.sv
panel_timebase.sv
power_monitor.sv
panel_control.sv
refresh_requester.sv
dga_decode_top.sv
dga_tb.sv

// ==== dga_decode_top.sv ====
////////////////////////////////////////////////////////////////////////////
// DGA panel and power decode, top level
// Timebase, power monitor, panel control and refresh requester
////////////////////////////////////////////////////////////////////////////
module dga_decode_top import dga_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // Timebase controls
  input  logic             test_en,
  input  logic             sel_5ms,
  // Supply
  input  logic             power_sense,
  input  logic             pwcl,
  // Operator panel, active low
  input  logic             stop_n,
  input  logic             sstop_n,
  input  logic             start_n,
  input  logic             load_n,
  input  logic             continue_n,
  input  logic             prq_n,
  input  logic             emcl_n,
  input  logic             clrti_n,
  // Memory refresh handshake
  input  logic             ref_ack,
  output logic             ref_req,
  output logic             bus_timeout,
  // Status
  output logic             power_fail_n,
  output logic             stopped,
  output logic             master_clear,
  output logic [IDB_W-1:0] idb,
  output logic             pan_n,
  output logic             pan_osc
);

  logic power_fail;

  dga_tick_if tick_bus ();

  panel_timebase u_timebase (
    .clk     (clk),
    .rst     (rst),
    .test_en (test_en),
    .sel_5ms (sel_5ms),
    .tick    (tick_bus.src)
  );

  power_monitor u_power (
    .clk         (clk),
    .rst         (rst),
    .power_sense (power_sense),
    .pwcl        (pwcl),
    .tick        (tick_bus.sink),
    .power_fail  (power_fail)
  );

  panel_control u_panel (
    .clk          (clk),
    .rst          (rst),
    .stop_n       (stop_n),
    .sstop_n      (sstop_n),
    .start_n      (start_n),
    .load_n       (load_n),
    .continue_n   (continue_n),
    .prq_n        (prq_n),
    .emcl_n       (emcl_n),
    .clrti_n      (clrti_n),
    .power_fail   (power_fail),
    .tick         (tick_bus.sink),
    .stopped      (stopped),
    .master_clear (master_clear),
    .idb          (idb),
    .pan_n        (pan_n)
  );

  refresh_requester u_refresh (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick_bus.sink),
    .ref_req     (ref_req),
    .ref_ack     (ref_ack),
    .bus_timeout (bus_timeout)
  );

  // Bus side wants power fail active low
  assign power_fail_n = ~power_fail;
  assign pan_osc      = tick_bus.pan_osc;

endmodule

// ==== dga_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// DGA panel and power decode package
// Divider ratios, hold and timeout counts, counter widths, refresh FSM
// state codes and the panel status codes shown on the internal data bus
////////////////////////////////////////////////////////////////////////////
package dga_pkg;

  // Timebase ratios
  // clk cycles per prescale tick
  localparam int PRESCALE_DIV = 16;
  // Prescale ticks per RTC tick, normal mode
  localparam int RTC_DIV_20MS = 8;
  // Prescale ticks per RTC tick, 5 ms mode
  localparam int RTC_DIV_5MS  = 2;
  // clk cycles per refresh tick
  localparam int REF_DIV      = 24;

  // Power good must hold this many prescale ticks
  localparam int PWR_HOLD     = 4;
  // clk cycles of unanswered refresh request before timeout
  localparam int REF_TIMEOUT  = 20;

  // Counter widths
  localparam int PRE_CNT_W  = $clog2(PRESCALE_DIV);
  localparam int RTC_CNT_W  = $clog2(RTC_DIV_20MS);
  localparam int REF_CNT_W  = $clog2(REF_DIV);
  localparam int HOLD_CNT_W = $clog2(PWR_HOLD + 1);
  localparam int TOUT_CNT_W = $clog2(REF_TIMEOUT + 1);

  // Refresh handshake FSM
  localparam int             REF_ST_W    = 2;
  localparam logic [REF_ST_W-1:0] REF_IDLE = 2'd0;
  // ref_req high, waiting for ack
  localparam logic [REF_ST_W-1:0] REF_REQ  = 2'd1;
  // ref_req dropped, waiting for ack to fall
  localparam logic [REF_ST_W-1:0] REF_WAIT = 2'd2;

  // Status code on internal data bus, highest priority first
  localparam int               IDB_W    = 3;
  localparam logic [IDB_W-1:0] IDB_MCL  = 3'd7;
  localparam logic [IDB_W-1:0] IDB_LOAD = 3'd6;
  localparam logic [IDB_W-1:0] IDB_CONT = 3'd5;
  localparam logic [IDB_W-1:0] IDB_RST  = 3'd4;
  localparam logic [IDB_W-1:0] IDB_PRQ  = 3'd2;
  localparam logic [IDB_W-1:0] IDB_RTC  = 3'd1;
  localparam logic [IDB_W-1:0] IDB_NONE = 3'd0;

endpackage

// ==== dga_tb_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// Test sequences for the DGA decode testbench
////////////////////////////////////////////////////////////////////////////
`ifndef DGA_TB_TASKS_SVH
`define DGA_TB_TASKS_SVH

task automatic reset_test();
  @(negedge clk);
  check_val("reset idb", IDB_NONE, idb);
  check_val("reset pan_n", 1, pan_n);
  check_val("reset stopped", 0, stopped);
  check_val("reset master_clear", 0, master_clear);
  check_val("reset power_fail_n", 1, power_fail_n);
  check_val("reset ref_req", 0, ref_req);
  check_val("reset bus_timeout", 0, bus_timeout);
endtask

// Wait until sig matches val, n cycles at most
task automatic wait_for(input string what, ref logic sig, input logic val,
                        input int lim, output int n);
  n = 0;
  while (sig !== val && n < lim) begin
    @(negedge clk);
    n++;
  end
  if (sig !== val) begin
    $display("Timeout waiting for %s", what);
    tout_cnt++;
  end
endtask

task automatic panel_random_test();
  logic [7:0] r;
  chk_en = 1'b1;
  repeat (400) begin
    @(negedge clk);
    r = rand_bits(4);
    @(posedge clk);
    stop_n     <= !(r == 0 || r == 1);
    start_n    <= !(r == 2 || r == 3 || r == 12);
    load_n     <= !(r == 4 || r == 5);
    continue_n <= !(r == 6 || r == 7);
    prq_n      <= !(r == 8);
    clrti_n    <= !(r == 9);
    emcl_n     <= !(r == 10);
    sstop_n    <= !(r == 11);
  end
  @(posedge clk);
  {stop_n, sstop_n, start_n, load_n, continue_n, prq_n, clrti_n} <= '1;
  emcl_n <= 1'b0;
  @(posedge clk);
  emcl_n <= 1'b1;
  @(negedge clk);
  chk_en = 1'b0;
endtask

task automatic pulse_clrti();
  @(posedge clk) clrti_n <= 1'b0;
  @(posedge clk) clrti_n <= 1'b1;
endtask

task automatic wait_rtc(output int at);
  int n;
  n = 0;
  @(negedge clk);
  while (idb != IDB_RTC && n < 1000) begin
    @(negedge clk);
    n++;
  end
  if (idb != IDB_RTC) begin
    $display("Timeout waiting for an RTC event");
    tout_cnt++;
  end
  at = cyc;
endtask

task automatic rtc_measure(input logic sel, input logic ten);
  int t0, t1;
  @(posedge clk);
  sel_5ms <= sel;
  test_en <= ten;
  pulse_clrti();
  wait_rtc(t0);
  pulse_clrti();
  wait_rtc(t0);
  pulse_clrti();
  wait_rtc(t1);
  check_val(ten ? "rtc period test mode" : "rtc period", rtc_period(sel, ten), t1 - t0);
endtask

// Next panel oscillator edge, returns its cycle
task automatic wait_osc_edge(output int at);
  logic v;
  int n;
  n = 0;
  @(negedge clk);
  v = pan_osc;
  @(negedge clk);
  while (pan_osc === v && n < 4 * PRESCALE_DIV) begin
    @(negedge clk);
    n++;
  end
  if (pan_osc === v) begin
    $display("Timeout waiting for a panel oscillator edge");
    tout_cnt++;
  end
  at = cyc;
endtask

// Oscillator half period is one prescale interval
task automatic osc_measure();
  int t0, t1;
  wait_osc_edge(t0);
  wait_osc_edge(t1);
  check_val("pan_osc half period", PRESCALE_DIV, t1 - t0);
endtask

task automatic rtc_test();
  rtc_measure(1'b0, 1'b1);
  rtc_measure(1'b0, 1'b0);
  rtc_measure(1'b1, 1'b0);
  osc_measure();
  pulse_clrti();
endtask

task automatic power_test();
  int n;
  @(posedge clk);
  test_en <= 1'b1;
  power_sense <= 1'b0;
  @(posedge clk);
  @(negedge clk);
  check_val("power_fail_n on loss", 0, power_fail_n);
  @(negedge clk);
  check_val("master_clear on loss", 1, master_clear);
  // Plain restore
  @(posedge clk) power_sense <= 1'b1;
  wait_for("power release", power_fail_n, 1'b1, 40, n);
  if (n < pwr_release_ticks() || n > pwr_release_ticks() + 1) begin
    $display("FAILED power release: expected %0d, actual %0d", pwr_release_ticks(), n);
    err_cnt++;
  end
  // Glitch inside the hold window
  @(posedge clk) power_sense <= 1'b0;
  @(posedge clk) power_sense <= 1'b1;
  repeat (2) @(posedge clk);
  power_sense <= 1'b0;
  @(posedge clk) power_sense <= 1'b1;
  wait_for("power release after glitch", power_fail_n, 1'b1, 40, n);
  if (n < pwr_release_ticks() || n > pwr_release_ticks() + 1) begin
    $display("FAILED power glitch restart: expected %0d, actual %0d",
             pwr_release_ticks(), n);
    err_cnt++;
  end
endtask

task automatic refresh_test();
  int n, start_cyc, done0;
  @(negedge clk);
  done0 = ref_done;
  start_cyc = cyc;
  repeat (20 * REF_DIV) @(negedge clk);
  n = ref_done - done0;
  if (n < (cyc - start_cyc) / REF_DIV - 1 || n > (cyc - start_cyc) / REF_DIV + 1) begin
    $display("FAILED refresh count: expected %0d, actual %0d", (cyc - start_cyc) / REF_DIV, n);
    err_cnt++;
  end
  // Withheld acknowledge
  wait_for("refresh idle", ref_req, 1'b0, 40, n);
  ack_hold = 1'b1;
  wait_for("refresh request", ref_req, 1'b1, 4 * REF_DIV, n);
  wait_for("bus timeout", bus_timeout, 1'b1, 4 * REF_TIMEOUT, n);
  check_val("bus timeout delay", REF_TIMEOUT, n);
  ack_hold = 1'b0;
  wait_for("bus timeout release", bus_timeout, 1'b0, 40, n);
  wait_for("refresh drop", ref_req, 1'b0, 40, n);
endtask

`endif

// ==== dga_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the DGA panel and power decode
// Panel model with cycle compare, memory responder, handshake monitor
////////////////////////////////////////////////////////////////////////////
module dga_tb import dga_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, rst, test_en, sel_5ms, power_sense, pwcl;
  logic stop_n, sstop_n, start_n, load_n, continue_n, prq_n, emcl_n, clrti_n;
  logic ref_ack, ref_req, bus_timeout, power_fail_n, stopped, master_clear;
  logic [IDB_W-1:0] idb;
  logic pan_n, pan_osc;

  int err_cnt = 0;
  int tout_cnt = 0;
  int cyc = 0;
  int ref_done = 0;
  logic [31:0] lfsr = 32'hcb83;
  logic chk_en = 1'b0;
  logic ack_hold = 1'b0;
  // Panel model state
  logic m_stop, m_load, m_cont, m_rst, m_rtc, m_pan_n;
  logic [IDB_W-1:0] m_idb;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  dga_decode_top UUT (.*);

  // Galois LFSR, one step per bit
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // Expected status code by priority
  function automatic logic [IDB_W-1:0] idb_ref(input logic mcl, ld, ct, rq, prq, rtc);
    if (mcl) return IDB_MCL;
    if (ld) return IDB_LOAD;
    if (ct) return IDB_CONT;
    if (rq) return IDB_RST;
    if (prq) return IDB_PRQ;
    if (rtc) return IDB_RTC;
    return IDB_NONE;
  endfunction

  // Expected RTC period in clk cycles
  function automatic int rtc_period(input logic sel, input logic ten);
    return (ten ? 1 : PRESCALE_DIV) * (sel ? RTC_DIV_5MS : RTC_DIV_20MS);
  endfunction

  // Prescale ticks from restore to release
  function automatic int pwr_release_ticks();
    return PWR_HOLD;
  endfunction

  task automatic check_val(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  // Panel latch model, valid while supply stays good
  always @(posedge clk) begin : panel_model
    logic mcl, s_set, s_clr, l_clr, n_load, n_cont, n_rst, n_rtc;
    if (rst) begin
      {m_stop, m_load, m_cont, m_rst, m_rtc} <= '0;
      m_idb   <= IDB_NONE;
      m_pan_n <= 1'b1;
    end else begin
      mcl    = !emcl_n || !power_sense || pwcl;
      s_set  = !stop_n || !sstop_n || mcl;
      s_clr  = !start_n && !s_set;
      l_clr  = mcl || !clrti_n || !m_stop || s_clr;
      n_load = !l_clr && (m_load || !load_n);
      n_cont = !l_clr && (m_cont || !continue_n);
      n_rst  = !l_clr && (m_rst || !load_n);
      // Tick read from the timebase as an event source only
      n_rtc  = !(!clrti_n || mcl) && (m_rtc || UUT.tick_bus.rtc_tick);
      m_stop <= s_set || (m_stop && !s_clr);
      {m_load, m_cont, m_rst, m_rtc} <= {n_load, n_cont, n_rst, n_rtc};
      m_idb  <= idb_ref(mcl, n_load, n_cont, n_rst, !prq_n, n_rtc);
      m_pan_n <= (idb_ref(mcl, n_load, n_cont, n_rst, !prq_n, n_rtc) == IDB_NONE)
                 || !sstop_n;
    end
  end

  // Cycle compare against the model
  always @(negedge clk) begin
    if (chk_en) begin
      check_val("panel idb", m_idb, idb);
      check_val("panel pan_n", m_pan_n, pan_n);
      check_val("panel stopped", m_stop, stopped);
    end
  end

  // Memory responder with random ack delay
  initial begin : responder
    int dly;
    dly = 0;
    forever begin
      @(posedge clk);
      if (ref_ack) begin
        if (!ref_req) ref_ack <= 1'b0;
      end else if (ref_req && !ack_hold) begin
        if (dly == 0) ref_ack <= 1'b1;
        else dly--;
      end else begin
        dly = rand_bits(3);
      end
    end
  end

  // Four-phase order monitor
  always @(negedge clk) begin : hs_monitor
    logic p_req, p_ack;
    if (!rst) begin
      if (ref_req && !p_req && p_ack) begin
        $display("Refresh request rose while acknowledge was still high");
        err_cnt++;
      end
      if (!ref_req && p_req && !p_ack) begin
        $display("Refresh request dropped before acknowledge");
        err_cnt++;
      end
      if (!ref_req && p_req) ref_done++;
    end
    p_req = ref_req;
    p_ack = ref_ack;
  end

  `include "dga_tb_tasks.svh"

  initial begin
    rst = 1'b1;
    {test_en, sel_5ms, pwcl, ref_ack} = '0;
    power_sense = 1'b1;
    {stop_n, sstop_n, start_n, load_n, continue_n, prq_n, emcl_n, clrti_n} = '1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    reset_test();
    panel_random_test();
    rtc_test();
    power_test();
    refresh_test();
    $display("Done: %0d errors, %0d timeouts", err_cnt, tout_cnt);
    if (err_cnt == 0 && tout_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== dga_tick_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Timebase tick bundle
// One-cycle tick pulses and the panel oscillator level
////////////////////////////////////////////////////////////////////////////
interface dga_tick_if;

  // One-cycle pulses
  logic pre_tick;
  logic rtc_tick;
  logic ref_tick;
  // Square wave, toggles per prescale tick
  logic pan_osc;

  // Driven by the timebase
  modport src (
    output pre_tick,
    output rtc_tick,
    output ref_tick,
    output pan_osc
  );

  // Consumers
  modport sink (
    input pre_tick,
    input rtc_tick,
    input ref_tick,
    input pan_osc
  );

endinterface

// ==== panel_control.sv ====
////////////////////////////////////////////////////////////////////////////
// Panel control
// Operator latches, master clear, RTC and panel request flags, and the
// priority encoder driving the status code on the internal data bus
////////////////////////////////////////////////////////////////////////////
module panel_control import dga_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // Panel switches, all active low levels
  input  logic             stop_n,
  input  logic             sstop_n,
  input  logic             start_n,
  input  logic             load_n,
  input  logic             continue_n,
  input  logic             prq_n,
  input  logic             emcl_n,
  input  logic             clrti_n,
  input  logic             power_fail,
  dga_tick_if.sink         tick,
  output logic             stopped,
  output logic             master_clear,
  output logic [IDB_W-1:0] idb,
  output logic             pan_n
);

  // Current latch state
  logic load_q;
  logic cont_q;
  logic rstrq_q;
  logic rtc_q;

  // Next state, registered outputs follow these so every input lands
  // on the outputs one edge later
  logic             mcl_d;
  logic             stop_set;
  logic             stop_clr;
  logic             stopped_d;
  logic             lat_clr;
  logic             load_d;
  logic             cont_d;
  logic             rstrq_d;
  logic             rtc_clr;
  logic             rtc_d;
  logic [IDB_W-1:0] idb_d;

  // Master clear from power fail or emergency clear
  assign mcl_d = power_fail | ~emcl_n;

  // Stop latch, set dominates start
  assign stop_set  = ~stop_n | ~sstop_n | mcl_d;
  assign stop_clr  = ~start_n & ~stop_set;
  assign stopped_d = stop_set | (stopped & ~stop_clr);

  // Operator latches only live while stopped
  assign lat_clr = mcl_d | ~clrti_n | ~stopped | stop_clr;
  assign load_d  = ~lat_clr & (load_q | ~load_n);
  assign cont_d  = ~lat_clr & (cont_q | ~continue_n);
  // Load also raises a reset request
  assign rstrq_d = ~lat_clr & (rstrq_q | ~load_n);

  // RTC flag, clear wins over a same-cycle tick
  assign rtc_clr = ~clrti_n | mcl_d;
  assign rtc_d   = ~rtc_clr & (rtc_q | tick.rtc_tick);

  // Priority encoder
  always_comb begin
    if (mcl_d) begin
      idb_d = IDB_MCL;
    end else if (load_d) begin
      idb_d = IDB_LOAD;
    end else if (cont_d) begin
      idb_d = IDB_CONT;
    end else if (rstrq_d) begin
      idb_d = IDB_RST;
    end else if (!prq_n) begin
      // Panel request is a level, not latched
      idb_d = IDB_PRQ;
    end else if (rtc_d) begin
      idb_d = IDB_RTC;
    end else begin
      idb_d = IDB_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stopped      <= 1'b0;
      master_clear <= 1'b0;
      load_q       <= 1'b0;
      cont_q       <= 1'b0;
      rstrq_q      <= 1'b0;
      rtc_q        <= 1'b0;
      idb          <= IDB_NONE;
      pan_n        <= 1'b1;
    end else begin
      stopped      <= stopped_d;
      master_clear <= mcl_d;
      load_q       <= load_d;
      cont_q       <= cont_d;
      rstrq_q      <= rstrq_d;
      rtc_q        <= rtc_d;
      idb          <= idb_d;
      // Panel attention, masked by single stop
      pan_n        <= (idb_d == IDB_NONE) | ~sstop_n;
    end
  end

  // Operator latches imply the machine is stopped
  latch_needs_stop: assert property (
    @(posedge clk) disable iff (rst)
    (load_q || cont_q || rstrq_q) |-> stopped
  );

endmodule

// ==== panel_timebase.sv ====
////////////////////////////////////////////////////////////////////////////
// Panel timebase
// Prescaler, RTC divider with 5 ms select, panel oscillator and
// memory refresh divider, all running on the oscillator clock
////////////////////////////////////////////////////////////////////////////
module panel_timebase import dga_pkg::*; (
  input  logic clk,
  input  logic rst,
  // Bypass prescaler, one prescale tick per clk
  input  logic test_en,
  // Short RTC period
  input  logic sel_5ms,
  dga_tick_if.src tick
);

  logic [PRE_CNT_W-1:0] pre_cnt;
  logic [RTC_CNT_W-1:0] rtc_cnt;
  logic [REF_CNT_W-1:0] ref_cnt;
  logic                 pre_hit;
  logic [RTC_CNT_W-1:0] rtc_term;
  logic                 rtc_end;
  logic                 ref_end;

  // Prescaler terminal count, or every cycle in test mode
  assign pre_hit = test_en | (pre_cnt == PRE_CNT_W'(PRESCALE_DIV - 1));

  // RTC terminal count picked by the 5 ms select
  assign rtc_term = sel_5ms ? RTC_CNT_W'(RTC_DIV_5MS - 1)
                            : RTC_CNT_W'(RTC_DIV_20MS - 1);
  // >= so a mode switch mid-count wraps at once
  assign rtc_end  = (rtc_cnt >= rtc_term);

  assign ref_end = (ref_cnt == REF_CNT_W'(REF_DIV - 1));

  // Prescaler and panel oscillator
  always_ff @(posedge clk) begin
    if (rst) begin
      pre_cnt       <= '0;
      tick.pre_tick <= 1'b0;
      tick.pan_osc  <= 1'b0;
    end else begin
      tick.pre_tick <= pre_hit;
      // Counter parked at zero in test mode
      if (pre_hit) begin
        pre_cnt <= '0;
      end else begin
        pre_cnt <= pre_cnt + 1'b1;
      end
      if (pre_hit) begin
        tick.pan_osc <= ~tick.pan_osc;
      end
    end
  end

  // RTC divider, advances on prescale ticks only
  always_ff @(posedge clk) begin
    if (rst) begin
      rtc_cnt       <= '0;
      tick.rtc_tick <= 1'b0;
    end else begin
      tick.rtc_tick <= pre_hit & rtc_end;
      if (pre_hit) begin
        rtc_cnt <= rtc_end ? '0 : rtc_cnt + 1'b1;
      end
    end
  end

  // Refresh divider, free running on clk
  always_ff @(posedge clk) begin
    if (rst) begin
      ref_cnt       <= '0;
      tick.ref_tick <= 1'b0;
    end else begin
      tick.ref_tick <= ref_end;
      ref_cnt       <= ref_end ? '0 : ref_cnt + 1'b1;
    end
  end

  // RTC ticks are a subset of prescale ticks
  rtc_on_prescale: assert property (
    @(posedge clk) disable iff (rst) tick.rtc_tick |-> tick.pre_tick
  );

endmodule

// ==== power_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// Power monitor
// Power-fail flag, set at once on bad supply, released after the
// supply has stayed good for a number of prescale ticks
////////////////////////////////////////////////////////////////////////////
module power_monitor import dga_pkg::*; (
  input  logic clk,
  input  logic rst,
  // High while supply is good
  input  logic power_sense,
  // Power clear request
  input  logic pwcl,
  dga_tick_if.sink tick,
  output logic power_fail
);

  logic [HOLD_CNT_W-1:0] hold_cnt;
  logic                  power_bad;
  logic                  hold_done;

  assign power_bad = ~power_sense | pwcl;
  // Last good prescale tick of the hold window
  assign hold_done = (hold_cnt == HOLD_CNT_W'(PWR_HOLD - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      power_fail <= 1'b0;
      hold_cnt   <= '0;
    end else if (power_bad) begin
      // Immediate set, any glitch restarts the hold window
      power_fail <= 1'b1;
      hold_cnt   <= '0;
    end else if (power_fail && tick.pre_tick) begin
      if (hold_done) begin
        power_fail <= 1'b0;
        hold_cnt   <= '0;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  // Flag must not drop while the supply is still bad
  fail_held_low_sense: assert property (
    @(posedge clk) disable iff (rst)
    (power_fail && !power_sense) |=> power_fail
  );

endmodule

// ==== refresh_requester.sv ====
////////////////////////////////////////////////////////////////////////////
// Refresh requester
// Turns refresh ticks into four-phase req/ack cycles to memory, keeps
// one pending request and flags a bus timeout on a missing acknowledge
////////////////////////////////////////////////////////////////////////////
module refresh_requester import dga_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  dga_tick_if.sink tick,
  output logic     ref_req,
  input  logic     ref_ack,
  output logic     bus_timeout
);

  logic [REF_ST_W-1:0]   state;
  logic [TOUT_CNT_W-1:0] wait_cnt;
  logic                  pending;
  logic                  want;
  logic                  start;
  logic                  tout_hit;

  // Work to do, fresh tick or one stored earlier
  assign want  = tick.ref_tick | pending;
  // New request only from rest with ack seen low
  assign start = want & ~ref_ack & ((state == REF_IDLE) | (state == REF_WAIT));

  assign tout_hit = (wait_cnt == TOUT_CNT_W'(REF_TIMEOUT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= REF_IDLE;
      ref_req     <= 1'b0;
      pending     <= 1'b0;
      wait_cnt    <= '0;
      bus_timeout <= 1'b0;
    end else begin
      // Tick while busy is stored, extra ticks are lost
      if (start) begin
        pending <= 1'b0;
      end else if (tick.ref_tick) begin
        pending <= 1'b1;
      end
      case (state)
        REF_REQ: begin
          if (ref_ack) begin
            ref_req     <= 1'b0;
            bus_timeout <= 1'b0;
            state       <= REF_WAIT;
          end else if (tout_hit) begin
            bus_timeout <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        REF_WAIT: begin
          // Back-to-back request straight from the ack-low phase
          if (!ref_ack) begin
            state <= start ? REF_REQ : REF_IDLE;
          end
        end
        default: begin
          state <= start ? REF_REQ : REF_IDLE;
        end
      endcase
      if (start) begin
        ref_req  <= 1'b1;
        wait_cnt <= '0;
      end
    end
  end

  // No new request while memory still shows the old acknowledge
  req_not_over_ack: assert property (
    @(posedge clk) disable iff (rst) (!ref_req && ref_ack) |=> !ref_req
  );

  // Request held until acknowledged
  req_held: assert property (
    @(posedge clk) disable iff (rst) (ref_req && !ref_ack) |=> ref_req
  );

endmodule
